//--- hdl/tensor_params.svh
`ifndef TENSOR_PARAMS_SVH
`define TENSOR_PARAMS_SVH

// width of one matrix element, results wrap modulo 2^16
`define TENSOR_ELEM_W 16

// lanes served by one octet
`define TENSOR_LANES 8

// warps that can each hold one buffered first-in-pair instruction
`define TENSOR_NUM_WARPS 4

// width of a warp id, must cover TENSOR_NUM_WARPS
`define TENSOR_NW_WIDTH 2

// width of a destination register id
`define TENSOR_NR_BITS 5

// entries in the result FIFO between the dot-product pipeline and writeback
`define TENSOR_RESULT_DEPTH 2

`endif

//--- hdl/tensor_pkg.sv
`default_nettype none

`include "tensor_params.svh"

package tensor_pkg;

    // one matrix element
    typedef logic [`TENSOR_ELEM_W-1:0] elem_t;

    // one element per lane of the octet
    typedef elem_t [`TENSOR_LANES-1:0] lanes_t;

    // half of an A or B operand as selected by the step field
    typedef elem_t [3:0] half_t;

    // 4x4 tile, first index is the row and second is the column
    typedef elem_t [3:0][3:0] tile_t;

    typedef logic [`TENSOR_NW_WIDTH-1:0] wid_t;

    typedef logic [`TENSOR_NR_BITS-1:0] rd_t;

endpackage

`default_nettype wire

//--- hdl/tile_if.sv
`default_nettype none

// one result tile with its warp and destination register
interface tile_if;

    logic              valid;
    logic              ready;
    tensor_pkg::wid_t  wid;
    tensor_pkg::rd_t   rd;
    tensor_pkg::tile_t tile;

    // the source keeps wid, rd and tile stable while valid waits for ready
    modport source (output valid, wid, rd, tile, input ready);

    modport sink (input valid, wid, rd, tile, output ready);

endinterface

`default_nettype wire

//--- hdl/hmma_dpu.sv
`default_nettype none

module hmma_dpu (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  tensor_pkg::elem_t [3:0][1:0] a_tile,
    input  tensor_pkg::half_t [1:0]      b_tile,
    input  tensor_pkg::tile_t            c_tile,
    input  tensor_pkg::wid_t             in_wid,
    input  tensor_pkg::rd_t              in_rd,
    tile_if.source                       out
);

    // stage 1 holds both partial products and the addend
    logic              s1_valid;
    tensor_pkg::tile_t s1_p0;
    tensor_pkg::tile_t s1_p1;
    tensor_pkg::tile_t s1_c;
    tensor_pkg::wid_t  s1_wid;
    tensor_pkg::rd_t   s1_rd;

    // stage 2 holds the finished tile
    logic              s2_valid;
    tensor_pkg::tile_t s2_d;
    tensor_pkg::wid_t  s2_wid;
    tensor_pkg::rd_t   s2_rd;

    logic advance;

    // both stages move together, so a full output stalls everything
    assign advance  = !s2_valid || out.ready;
    assign in_ready = advance;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    s1_p0[r][c] <= a_tile[r][0] * b_tile[0][c];
                    s1_p1[r][c] <= a_tile[r][1] * b_tile[1][c];
                end
            end
            s1_c   <= c_tile;
            s1_wid <= in_wid;
            s1_rd  <= in_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    s2_d[r][c] <= s1_c[r][c] + s1_p0[r][c] + s1_p1[r][c];
                end
            end
            s2_wid <= s1_wid;
            s2_rd  <= s1_rd;
        end
    end

    assign out.valid = s2_valid;
    assign out.wid   = s2_wid;
    assign out.rd    = s2_rd;
    assign out.tile  = s2_d;

endmodule

`default_nettype wire

//--- hdl/operand_pairing.sv
`default_nettype none

`include "tensor_params.svh"

module operand_pairing (
    input  logic                clk,
    input  logic                reset,
    input  logic                op_valid,
    input  logic                op_last_in_pair,
    input  logic [1:0]          op_step,
    input  tensor_pkg::wid_t    op_wid,
    input  tensor_pkg::rd_t     op_rd,
    input  tensor_pkg::lanes_t  op_a,
    input  tensor_pkg::lanes_t  op_b,
    input  tensor_pkg::lanes_t  op_c,
    output logic                op_ready,
    tile_if.source              out
);

    // first halves of each warp, waiting for the second instruction
    tensor_pkg::half_t  a_buf [`TENSOR_NUM_WARPS];
    tensor_pkg::half_t  b_buf [`TENSOR_NUM_WARPS];
    tensor_pkg::lanes_t c_buf [`TENSOR_NUM_WARPS];
    logic [`TENSOR_NUM_WARPS-1:0] pending;

    tensor_pkg::half_t a_half;
    tensor_pkg::half_t b_half;

    tensor_pkg::elem_t [3:0][1:0] a_tile;
    tensor_pkg::half_t [1:0]      b_tile;
    tensor_pkg::tile_t            c_tile;

    logic first_fire;
    logic second_fire;

    assign first_fire  = op_valid && op_ready && !op_last_in_pair;
    assign second_fire = op_valid && op_ready && op_last_in_pair;

    // step bit 0 picks lanes 0,1,4,5 or 2,3,6,7 of A
    // step bit 1 picks the low or high four lanes of B
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            a_half[i]     = op_a[2 * op_step[0] + i];
            a_half[i + 2] = op_a[2 * op_step[0] + i + 4];
        end
        for (int i = 0; i < 4; i++) begin
            b_half[i] = op_b[4 * op_step[1] + i];
        end
    end

    always_ff @(posedge clk) begin
        if (first_fire) begin
            a_buf[op_wid] <= a_half;
            b_buf[op_wid] <= b_half;
            c_buf[op_wid] <= op_c;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (first_fire) begin
            pending[op_wid] <= 1'b1;
        end else if (second_fire) begin
            pending[op_wid] <= 1'b0;
        end
    end

    // the buffered instruction supplies k = 0 of A and row 0 of B
    // C columns alternate between the buffered and the current lanes
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            a_tile[r][0] = a_buf[op_wid][r];
            a_tile[r][1] = a_half[r];
        end
        b_tile[0] = b_buf[op_wid];
        b_tile[1] = b_half;
        for (int r = 0; r < 4; r++) begin
            c_tile[r][0] = c_buf[op_wid][(r / 2) * 4 + (r % 2)];
            c_tile[r][1] = op_c[(r / 2) * 4 + (r % 2)];
            c_tile[r][2] = c_buf[op_wid][(r / 2) * 4 + (r % 2) + 2];
            c_tile[r][3] = op_c[(r / 2) * 4 + (r % 2) + 2];
        end
    end

    hmma_dpu hmma_dpu_inst (
        .clk      (clk),
        .reset    (reset),
        .in_valid (op_valid && op_last_in_pair),
        .in_ready (op_ready),
        .a_tile   (a_tile),
        .b_tile   (b_tile),
        .c_tile   (c_tile),
        .in_wid   (op_wid),
        .in_rd    (op_rd),
        .out      (out)
    );

    // a second half must find its first half already buffered
    second_needs_first: assert property (
        @(posedge clk) disable iff (reset) second_fire |-> pending[op_wid]
    );

endmodule

`default_nettype wire

//--- hdl/result_fifo.sv
`default_nettype none

`include "tensor_params.svh"

module result_fifo (
    input  logic   clk,
    input  logic   reset,
    tile_if.sink   in,
    tile_if.source out
);

    localparam int DEPTH = `TENSOR_RESULT_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    tensor_pkg::wid_t  wid_mem  [DEPTH];
    tensor_pkg::rd_t   rd_mem   [DEPTH];
    tensor_pkg::tile_t tile_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    assign in.ready  = (count != CNT_W'(DEPTH));
    assign out.valid = (count != '0);
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            wid_mem[wr_ptr]  <= in.wid;
            rd_mem[wr_ptr]   <= in.rd;
            tile_mem[wr_ptr] <= in.tile;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign out.wid  = wid_mem[rd_ptr];
    assign out.rd   = rd_mem[rd_ptr];
    assign out.tile = tile_mem[rd_ptr];

    // a tile refused by the full FIFO waits unchanged at the input until there is room
    no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        (in.valid && !in.ready) |=>
            (in.valid && $stable(in.wid) && $stable(in.rd) && $stable(in.tile))
    );

    // the consumer only takes a tile while one is stored
    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) out.ready |-> out.valid
    );

endmodule

`default_nettype wire

//--- hdl/writeback_split.sv
`default_nettype none

`include "tensor_params.svh"

module writeback_split (
    input  logic               clk,
    input  logic               reset,
    tile_if.sink               in,
    output logic               result_valid,
    input  logic               result_ready,
    output tensor_pkg::wid_t   result_wid,
    output tensor_pkg::rd_t    result_rd,
    output logic               result_beat,
    output tensor_pkg::lanes_t result_data
);

    // 0 while columns 0 and 2 are presented, 1 for columns 1 and 3
    logic beat;
    logic accept;

    assign accept       = result_valid && result_ready;
    assign result_valid = in.valid;
    assign result_wid   = in.wid;
    assign result_rd    = in.rd;
    assign result_beat  = beat;

    // the tile leaves the FIFO only once its second beat is taken
    assign in.ready = accept && beat;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat <= 1'b0;
        end else if (accept) begin
            beat <= ~beat;
        end
    end

    // lane bit 0 picks the row within a pair, bit 1 the column pair
    // and bit 2 the upper two rows
    for (genvar l = 0; l < `TENSOR_LANES; l++) begin : g_lane
        localparam int ROW = 2 * (l / 4) + (l % 2);
        localparam int COL = 2 * ((l / 2) % 2);
        assign result_data[l] = beat ? in.tile[ROW][COL + 1] : in.tile[ROW][COL];
    end

    // a beat that is held back stays on the bus unchanged
    beat_held_stable: assert property (
        @(posedge clk) disable iff (reset)
        (result_valid && !result_ready) |=> (result_valid && $stable(result_data))
    );

endmodule

`default_nettype wire

//--- hdl/tensor_octet_top.sv
`default_nettype none

module tensor_octet_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               op_valid,
    output logic               op_ready,
    input  tensor_pkg::wid_t   op_wid,
    input  tensor_pkg::rd_t    op_rd,
    input  logic               op_last_in_pair,
    input  logic [1:0]         op_step,
    input  tensor_pkg::lanes_t op_a,
    input  tensor_pkg::lanes_t op_b,
    input  tensor_pkg::lanes_t op_c,
    output logic               result_valid,
    input  logic               result_ready,
    output tensor_pkg::wid_t   result_wid,
    output tensor_pkg::rd_t    result_rd,
    output logic               result_beat,
    output tensor_pkg::lanes_t result_data
);

    tile_if dpu_if ();
    tile_if fifo_if ();

    operand_pairing operand_pairing_inst (
        .clk             (clk),
        .reset           (reset),
        .op_valid        (op_valid),
        .op_last_in_pair (op_last_in_pair),
        .op_step         (op_step),
        .op_wid          (op_wid),
        .op_rd           (op_rd),
        .op_a            (op_a),
        .op_b            (op_b),
        .op_c            (op_c),
        .op_ready        (op_ready),
        .out             (dpu_if)
    );

    result_fifo result_fifo_inst (
        .clk   (clk),
        .reset (reset),
        .in    (dpu_if),
        .out   (fifo_if)
    );

    writeback_split writeback_split_inst (
        .clk          (clk),
        .reset        (reset),
        .in           (fifo_if),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_wid   (result_wid),
        .result_rd    (result_rd),
        .result_beat  (result_beat),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

//--- tests/tensor_model.svh
`ifndef TENSOR_MODEL_SVH
`define TENSOR_MODEL_SVH

// A half from lanes 0,1,4,5 when step bit 0 is clear, else from lanes 2,3,6,7
function automatic tensor_pkg::half_t a_half_for_step(input tensor_pkg::lanes_t a,
                                                      input logic [1:0] step);
    tensor_pkg::half_t h;
    int base;
    base = step[0] ? 2 : 0;
    h[0] = a[base];
    h[1] = a[base + 1];
    h[2] = a[base + 4];
    h[3] = a[base + 5];
    return h;
endfunction

// B half from the low four lanes when step bit 1 is clear, else the high four
function automatic tensor_pkg::half_t b_half_for_step(input tensor_pkg::lanes_t b,
                                                      input logic [1:0] step);
    tensor_pkg::half_t h;
    for (int i = 0; i < 4; i++) begin
        h[i] = step[1] ? b[i + 4] : b[i];
    end
    return h;
endfunction

// D = C + A x B with the first instruction as k = 0 and the second as k = 1
function automatic tensor_pkg::tile_t expected_tile(
    input tensor_pkg::lanes_t fa, input tensor_pkg::lanes_t fb, input tensor_pkg::lanes_t fc,
    input logic [1:0] fstep,
    input tensor_pkg::lanes_t sa, input tensor_pkg::lanes_t sb, input tensor_pkg::lanes_t sc,
    input logic [1:0] sstep);
    tensor_pkg::tile_t d;
    tensor_pkg::half_t a0;
    tensor_pkg::half_t a1;
    tensor_pkg::half_t b0;
    tensor_pkg::half_t b1;
    tensor_pkg::elem_t c;
    int row_lane [4] = '{0, 1, 4, 5};
    a0 = a_half_for_step(fa, fstep);
    a1 = a_half_for_step(sa, sstep);
    b0 = b_half_for_step(fb, fstep);
    b1 = b_half_for_step(sb, sstep);
    for (int r = 0; r < 4; r++) begin
        for (int col = 0; col < 4; col++) begin
            // even columns come from the buffered C, odd ones from the current C
            c = (col % 2 == 0) ? fc[row_lane[r] + 2 * (col / 2)] : sc[row_lane[r] + 2 * (col / 2)];
            d[r][col] = c + a0[r] * b0[col] + a1[r] * b1[col];
        end
    end
    return d;
endfunction

// beat 0 carries columns 0 and 2, beat 1 carries columns 1 and 3
function automatic tensor_pkg::lanes_t beat_lanes(input tensor_pkg::tile_t d, input logic beat);
    tensor_pkg::lanes_t l;
    int col;
    col = beat ? 1 : 0;
    l[0] = d[0][col];
    l[1] = d[1][col];
    l[2] = d[0][col + 2];
    l[3] = d[1][col + 2];
    l[4] = d[2][col];
    l[5] = d[3][col];
    l[6] = d[2][col + 2];
    l[7] = d[3][col + 2];
    return l;
endfunction

`endif

//--- tests/tensor_octet_tb.sv
`default_nettype none

`include "tensor_params.svh"

module tensor_octet_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_PAIRS = 12;
    localparam int CYCLES_PER_ENTRY = 40;

    typedef struct packed {
        tensor_pkg::wid_t wid;
        tensor_pkg::rd_t  rd;
        logic             last;
        logic [1:0]       step;
        logic [31:0]      seed_a;
        logic [31:0]      seed_b;
        logic [31:0]      seed_c;
        logic [7:0]       hold;
        logic             rnd_ready;
    } op_entry_t;

    typedef struct packed {
        tensor_pkg::wid_t   wid;
        tensor_pkg::rd_t    rd;
        logic               beat;
        tensor_pkg::lanes_t data;
    } beat_t;

    logic               clk;
    logic               reset;
    logic               op_valid;
    logic               op_ready;
    tensor_pkg::wid_t   op_wid;
    tensor_pkg::rd_t    op_rd;
    logic               op_last_in_pair;
    logic [1:0]         op_step;
    tensor_pkg::lanes_t op_a;
    tensor_pkg::lanes_t op_b;
    tensor_pkg::lanes_t op_c;
    logic               result_valid;
    logic               result_ready;
    tensor_pkg::wid_t   result_wid;
    tensor_pkg::rd_t    result_rd;
    logic               result_beat;
    tensor_pkg::lanes_t result_data;

    op_entry_t op_table[$];
    beat_t     exp_q[$];

    // first instruction of each warp as the model sees it
    tensor_pkg::lanes_t buf_a [`TENSOR_NUM_WARPS];
    tensor_pkg::lanes_t buf_b [`TENSOR_NUM_WARPS];
    tensor_pkg::lanes_t buf_c [`TENSOR_NUM_WARPS];
    logic [1:0]         buf_step [`TENSOR_NUM_WARPS];

    int    hold_left;
    logic  random_ready;
    int    max_in_flight;
    logic  table_built;
    logic  held_valid;
    beat_t held;

    `include "tensor_model.svh"

    tensor_octet_top tensor_octet_top_inst (
        .clk             (clk),
        .reset           (reset),
        .op_valid        (op_valid),
        .op_ready        (op_ready),
        .op_wid          (op_wid),
        .op_rd           (op_rd),
        .op_last_in_pair (op_last_in_pair),
        .op_step         (op_step),
        .op_a            (op_a),
        .op_b            (op_b),
        .op_c            (op_c),
        .result_valid    (result_valid),
        .result_ready    (result_ready),
        .result_wid      (result_wid),
        .result_rd       (result_rd),
        .result_beat     (result_beat),
        .result_data     (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // an odd stride keeps all eight lanes distinct
    function automatic tensor_pkg::lanes_t spread_seed(input logic [31:0] seed);
        tensor_pkg::lanes_t v;
        for (int l = 0; l < `TENSOR_LANES; l++) begin
            v[l] = seed[15:0] + tensor_pkg::elem_t'(l) * (seed[31:16] | 16'h0001);
        end
        return v;
    endfunction

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic add_op(input int wid, input int rd, input logic last, input logic [1:0] step,
                          input logic [31:0] sa, input logic [31:0] sb, input logic [31:0] sc,
                          input int hold, input logic rnd);
        op_table.push_back({tensor_pkg::wid_t'(wid), tensor_pkg::rd_t'(rd), last, step,
                            sa, sb, sc, 8'(hold), rnd});
    endtask

    task automatic add_pair(input int wid, input int rd, input logic [1:0] first_step,
                            input logic [1:0] second_step, input logic [31:0] base,
                            input int hold, input logic rnd);
        add_op(wid, rd, 1'b0, first_step, base, base + 32'h0002_0111, base + 32'h0004_0222,
               hold, rnd);
        add_op(wid, rd, 1'b1, second_step, base + 32'h0006_0333, base + 32'h0008_0444,
               base + 32'h000a_0555, 0, rnd);
    endtask

    // result_ready is updated on every falling edge from the hold counter or the random source
    task automatic next_negedge();
        @(negedge clk);
        if (hold_left > 0) begin
            result_ready = 1'b0;
            hold_left--;
        end else if (random_ready) begin
            result_ready = 1'($urandom_range(1, 0));
        end else begin
            result_ready = 1'b1;
        end
    endtask

    task automatic apply_op(input op_entry_t e);
        tensor_pkg::lanes_t a;
        tensor_pkg::lanes_t b;
        tensor_pkg::lanes_t c;
        tensor_pkg::tile_t  d;
        a = spread_seed(e.seed_a);
        b = spread_seed(e.seed_b);
        c = spread_seed(e.seed_c);
        if (e.hold != 0) hold_left = e.hold;
        random_ready    = e.rnd_ready;
        op_valid        = 1'b1;
        op_wid          = e.wid;
        op_rd           = e.rd;
        op_last_in_pair = e.last;
        op_step         = e.step;
        op_a            = a;
        op_b            = b;
        op_c            = c;
        // op_ready only changes on rising edges, so it is settled here
        while (!op_ready) next_negedge();
        if (e.last) begin
            d = expected_tile(buf_a[e.wid], buf_b[e.wid], buf_c[e.wid], buf_step[e.wid],
                              a, b, c, e.step);
            exp_q.push_back({e.wid, e.rd, 1'b0, beat_lanes(d, 1'b0)});
            exp_q.push_back({e.wid, e.rd, 1'b1, beat_lanes(d, 1'b1)});
            if ((exp_q.size() + 1) / 2 > max_in_flight) max_in_flight = (exp_q.size() + 1) / 2;
        end else begin
            buf_a[e.wid]    = a;
            buf_b[e.wid]    = b;
            buf_c[e.wid]    = c;
            buf_step[e.wid] = e.step;
        end
        next_negedge();
    endtask

    always @(posedge clk) begin : monitor
        beat_t exp;
        if (!reset) begin
            if (held_valid) begin
                assert (result_valid && {result_wid, result_rd, result_beat, result_data} == held)
                else fail_run($sformatf("Error at %0d ns: beat changed while it was held", $time));
            end
            if (result_valid && result_ready) begin
                assert (exp_q.size() > 0)
                else fail_run("a writeback beat came out when no beat was expected");
                exp = exp_q.pop_front();
                assert (result_wid == exp.wid && result_rd == exp.rd)
                else fail_run($sformatf("Error at %0d ns: wid %0d rd %0d, expected wid %0d rd %0d",
                                        $time, result_wid, result_rd, exp.wid, exp.rd));
                assert (result_beat == exp.beat)
                else fail_run($sformatf("Error at %0d ns: beat %0d, expected beat %0d",
                                        $time, result_beat, exp.beat));
                assert (result_data == exp.data)
                else fail_run($sformatf("Error at %0d ns: data %h, expected %h",
                                        $time, result_data, exp.data));
            end
            held_valid = result_valid && !result_ready;
            held       = {result_wid, result_rd, result_beat, result_data};
        end
    end

    initial begin
        wait (table_built);
        repeat (op_table.size() * CYCLES_PER_ENTRY) @(posedge clk);
        fail_run($sformatf("the run timed out with %0d beats still expected", exp_q.size()));
    end

    initial begin
        void'($urandom(5));
        reset           = 1'b1;
        op_valid        = 1'b0;
        op_wid          = '0;
        op_rd           = '0;
        op_last_in_pair = 1'b0;
        op_step         = 2'd0;
        op_a            = '0;
        op_b            = '0;
        op_c            = '0;
        result_ready    = 1'b0;
        hold_left       = 0;
        random_ready    = 1'b0;
        max_in_flight   = 0;
        held_valid      = 1'b0;
        table_built     = 1'b0;

        // one pair on warp 0 with step 0
        add_pair(0, 3, 2'd0, 2'd0, 32'h0003_1000, 0, 1'b0);
        // every step value, back to back on warp 1
        for (int s = 0; s < 4; s++) begin
            add_pair(1, 8 + s, 2'(s), 2'(3 - s), 32'h0105_0020 * (s + 1), 0, 1'b0);
        end
        // first halves of all warps, then second halves out of order
        for (int w = 0; w < `TENSOR_NUM_WARPS; w++) begin
            add_op(w, 16 + w, 1'b0, 2'(w), 32'h0201_0300 + w, 32'h0403_0500 + w,
                   32'h0605_0700 + w, 0, 1'b0);
        end
        add_op(2, 18, 1'b1, 2'd1, 32'h0807_0900, 32'h0a09_0b00, 32'h0c0b_0d00, 0, 1'b0);
        add_op(0, 16, 1'b1, 2'd3, 32'h0e0d_0f00, 32'h100f_1100, 32'h1211_1300, 0, 1'b0);
        add_op(3, 19, 1'b1, 2'd0, 32'h1413_1500, 32'h1615_1700, 32'h1817_1900, 0, 1'b0);
        add_op(1, 17, 1'b1, 2'd2, 32'h1a19_1b00, 32'h1c1b_1d00, 32'h1e1d_1f00, 0, 1'b0);
        // result_ready held low long enough to fill the FIFO and stall the pipeline
        for (int w = 0; w < `TENSOR_NUM_WARPS; w++) begin
            add_pair(w, 24 + w, 2'(w), 2'(w + 1), 32'h2021_2200 * (w + 1), (w == 0) ? 30 : 0,
                     1'b0);
        end
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            add_pair($urandom_range(`TENSOR_NUM_WARPS - 1, 0), $urandom_range(31, 0),
                     2'($urandom_range(3, 0)), 2'($urandom_range(3, 0)), $urandom, 0, 1'b1);
        end
        table_built = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset        = 1'b0;
        result_ready = 1'b1;
        assert (!result_valid && op_ready)
        else fail_run("after reset result_valid was high or op_ready was low");

        foreach (op_table[i]) begin
            apply_op(op_table[i]);
        end
        op_valid     = 1'b0;
        random_ready = 1'b0;
        while (exp_q.size() != 0) next_negedge();
        repeat (8) next_negedge();

        assert (max_in_flight >= 2)
        else fail_run("back-to-back pairs never had two tiles in flight");

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
+incdir+tests
hdl/tensor_pkg.sv
hdl/tile_if.sv
hdl/hmma_dpu.sv
hdl/operand_pairing.sv
hdl/result_fifo.sv
hdl/writeback_split.sv
hdl/tensor_octet_top.sv
tests/tensor_octet_tb.sv
